//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD = 5 // 10 ns clock
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

//--- bench/mips_golden.txt
// words: counts (program, data, write-backs, stores), program from the reset pc,
// data from address 0, write-backs (pc, test<<8|reg, value), stores (address, data)
00000036 00000002 00000027 00000003
00000000 3c011234 34215678 2402fffd 24030ff0 00432021 00432823 00233024
00233825 00234026 0043482a 0062502a 00015900 240c0001 018c6021 018c6821
018d7021 01cc7823 24100007 24100009 02008821 8c120000 02439821 8c140004
24150002 0295b021 24170040 aee10000 aef30004 8ef80000 8ef90004 241a0055
aefa0008 8efb0008 241c0001 10640003 241d0011 27bd0022 14640002 241e0044
241e0099 13de0002 279c0001 241c0077 14000002 279c0001 0bf00031 241d0005
241d0066 24000123 340500f0 00003021 0bf00034 00000000
cafe0001 00000123
bfc00004 0101 12340000  bfc00008 0101 12345678  bfc0000c 0102 fffffffd
bfc00010 0103 00000ff0  bfc00014 0104 00000fed  bfc00018 0105 fffff00d
bfc0001c 0106 00000670  bfc00020 0107 12345ff8  bfc00024 0108 12345988
bfc00028 0109 00000001  bfc0002c 010a 00000000  bfc00030 010b 23456780
bfc00034 020c 00000001  bfc00038 020c 00000002  bfc0003c 020d 00000004
bfc00040 020e 00000006  bfc00044 020f 00000004  bfc00048 0210 00000007
bfc0004c 0210 00000009  bfc00050 0211 00000009
bfc00054 0312 cafe0001  bfc00058 0313 cafe0ff1  bfc0005c 0314 00000123
bfc00060 0315 00000002  bfc00064 0316 00000125
bfc00068 0417 00000040  bfc00074 0418 12345678  bfc00078 0419 cafe0ff1
bfc0007c 041a 00000055  bfc00084 041b 00000055
bfc00088 051c 00000001  bfc00090 051d 00000011  bfc00094 051d 00000033
bfc0009c 051e 00000044  bfc000a8 051c 00000002  bfc000b4 051c 00000003
bfc000bc 051d 00000005
bfc000c8 0605 000000f0  bfc000cc 0606 00000000
00000040 12345678  00000044 cafe0ff1  00000048 00000055

//--- bench/tb_mips.sv
`timescale 1ns/100ps

module tb_mips;

    localparam logic [31:0] RESET_PC = 32'hbfc00000;
    localparam int GOLD_WORDS = 512;
    localparam int DRAIN_CYCLES = 20; // catch stray writes after the last trace entry

    logic        clk;
    logic        rst;
    logic        inst_ce;
    logic [31:0] inst_addr, inst_rdata, fetch_off;
    logic        ram_ce, ram_we;
    logic [3:0]  ram_sel;
    logic [31:0] ram_addr, ram_wdata, ram_rdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] gold [GOLD_WORDS];
    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    int n_prog = 0, n_data = 0, n_wb = 0, n_st = 0;
    int wb_base = 0, st_base = 0;
    int wb_idx = 0, st_idx = 0;
    int checks = 0, errors = 0, test_checks = 0, test_errors = 0;
    int cycles = 0, cycle_limit = 0;

    clk_gen i_clk (.clk_o(clk));

    mips #(.RESET_PC(RESET_PC)) i_dut (
        .clk                 (clk),
        .rst                 (rst),
        .inst_ce_o           (inst_ce),
        .inst_addr_o         (inst_addr),
        .inst_rdata_i        (inst_rdata),
        .ram_ce_o            (ram_ce),
        .ram_we_o            (ram_we),
        .ram_sel_o           (ram_sel),
        .ram_addr_o          (ram_addr),
        .ram_data_o          (ram_wdata),
        .ram_data_i          (ram_rdata),
        .debug_wb_pc_o       (debug_wb_pc),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata)
    );

    // both memories answer in the same cycle
    assign fetch_off  = inst_addr - RESET_PC;
    assign inst_rdata = (inst_ce && fetch_off < 32'd1024) ? imem[fetch_off[9:2]] : 32'h0;
    assign ram_rdata  = ram_ce ? dmem[ram_addr[9:2]] : 32'h0;

    always @(posedge clk) begin : store_model
        logic [31:0] word;
        if (ram_ce && ram_we) begin
            word = dmem[ram_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (ram_sel[b]) begin
                    word[8*b +: 8] = ram_wdata[8*b +: 8];
                end
            end
            dmem[ram_addr[9:2]] <= word;
        end
    end

    function automatic string test_label(input int t);
        case (t)
            1: return "alu register and immediate ops";
            2: return "forwarding from execute and memory";
            3: return "load-use stall";
            4: return "store and load back";
            5: return "branches, jump and delay slots";
            6: return "register 0";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input int t);
        $display("test %0d (%s): %0d checks, %0d errors", t, test_label(t), test_checks,
                 test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic verify_write_back();
        int base;
        base = wb_base + 3 * wb_idx;
        if (wb_idx >= n_wb) begin
            $display("unexpected extra write-back to r%0d at time %0t", debug_wb_rf_wnum, $time);
            errors++;
        end else begin
            checks++;
            test_checks++;
            if (debug_wb_pc !== gold[base] || debug_wb_rf_wnum !== gold[base+1][4:0] ||
                debug_wb_rf_wdata !== gold[base+2] || debug_wb_rf_wen !== 4'hf) begin
                $display("error at %0t: write-back %0d expected pc %h r%0d %h, got pc %h r%0d %h",
                         $time, wb_idx, gold[base], gold[base+1][4:0], gold[base+2],
                         debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
                errors++;
                test_errors++;
            end
            wb_idx++;
            // tag byte holds the test number
            if (wb_idx == n_wb || gold[base+4][15:8] != gold[base+1][15:8]) begin
                report_test(gold[base+1][15:8]);
            end
        end
    endtask

    task automatic check_store();
        int base;
        base = st_base + 2 * st_idx;
        if (st_idx >= n_st) begin
            $display("unexpected extra store to address %h at time %0t", ram_addr, $time);
            errors++;
        end else begin
            checks++;
            test_checks++;
            if (ram_addr !== gold[base] || ram_wdata !== gold[base+1] || ram_sel !== 4'hf) begin
                $display("error at %0t: store %0d expected %h <- %h sel f, got %h <- %h sel %h",
                         $time, st_idx, gold[base], gold[base+1], ram_addr, ram_wdata, ram_sel);
                errors++;
                test_errors++;
            end
            st_idx++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst && debug_wb_rf_wen != 4'h0) begin
            verify_write_back();
        end
        if (!rst && ram_ce && ram_we) begin
            check_store();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles: %0d of %0d write-backs, %0d of %0d stores seen",
                     cycles, wb_idx, n_wb, st_idx, n_st);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin : run_tests
        int i;
        rst = 1'b1;
        for (i = 0; i < 256; i++) begin
            dmem[i] = 32'hd0000000 | (i << 2);
        end
        $readmemh("bench/mips_golden.txt", gold);
        if (^{gold[0], gold[1], gold[2], gold[3]} === 1'bx || gold[0] == 0 ||
            gold[0] > 256 || gold[1] > 256) begin
            $display("golden file bench/mips_golden.txt is missing or malformed");
            errors++;
        end else begin
            n_prog  = gold[0];
            n_data  = gold[1];
            n_wb    = gold[2];
            n_st    = gold[3];
            wb_base = 4 + n_prog + n_data;
            st_base = wb_base + 3 * n_wb;
            for (i = 0; i < n_prog; i++) begin
                imem[i] = gold[4 + i];
            end
            for (i = 0; i < n_data; i++) begin
                dmem[i] = gold[4 + n_prog + i];
            end
            cycle_limit = 20 * n_prog + 100;
            repeat (8) @(posedge clk);
            #1 rst = 1'b0;
            while (wb_idx < n_wb || st_idx < n_st) begin
                @(posedge clk);
            end
            repeat (DRAIN_CYCLES) @(posedge clk);
        end
        $display("%0d checks, %0d errors, %0d of %0d write-backs, %0d of %0d stores",
                 checks, errors, wb_idx, n_wb, st_idx, n_st);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rtl/ex.sv
`timescale 1ns/100ps

module ex
    import mips_pkg::*;
(
    input  alu_op_e               alu_op_i,
    input  logic [31:0]           reg1_i,
    input  logic [31:0]           reg2_i,
    input  logic                  wreg_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic [31:0]           store_data_i,
    output logic                  wreg_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic [31:0]           wdata_o,
    output logic                  is_load_o,
    output logic [31:0]           mem_addr_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic [31:0]           store_data_o
);

    logic [31:0] sum;

    assign sum = reg1_i + reg2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD: wdata_o = sum;
            ALU_SUB: wdata_o = reg1_i - reg2_i;
            ALU_AND: wdata_o = reg1_i & reg2_i;
            ALU_OR:  wdata_o = reg1_i | reg2_i;
            ALU_XOR: wdata_o = reg1_i ^ reg2_i;
            ALU_SLT: wdata_o = {31'b0, $signed(reg1_i) < $signed(reg2_i)};
            ALU_SLL: wdata_o = reg2_i << reg1_i[4:0];
            ALU_LUI: wdata_o = reg2_i; // already shifted in decode
            default: wdata_o = '0;
        endcase
    end

    assign mem_addr_o   = sum; // base plus offset
    assign is_load_o    = mem_read_i;
    assign wreg_o       = wreg_i;
    assign wd_o         = wd_i;
    assign mem_read_o   = mem_read_i;
    assign mem_write_o  = mem_write_i;
    assign store_data_o = store_data_i;

endmodule

//--- rtl/ex_mem.sv
`timescale 1ns/100ps

module ex_mem
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wreg_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic [31:0]           wdata_i,
    input  logic [31:0]           mem_addr_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic [31:0]           store_data_i,
    input  logic [31:0]           pc_i,
    output logic                  mem_wreg_o,
    output logic [REG_ADDR_W-1:0] mem_wd_o,
    output logic [31:0]           mem_wdata_o,
    output logic [31:0]           mem_addr_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic [31:0]           mem_store_data_o,
    output logic [31:0]           mem_pc_o
);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wreg_o  <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
        end else begin
            mem_wreg_o  <= wreg_i;
            mem_read_o  <= mem_read_i;
            mem_write_o <= mem_write_i;
        end
    end

    always_ff @(posedge clk) begin
        mem_wd_o         <= wd_i;
        mem_wdata_o      <= wdata_i;
        mem_addr_o       <= mem_addr_i;
        mem_store_data_o <= store_data_i;
        mem_pc_o         <= pc_i;
    end

endmodule

//--- rtl/id.sv
`timescale 1ns/100ps

module id
    import mips_pkg::*;
(
    input  logic                  rst,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           inst_i,
    input  logic [31:0]           reg1_data_i,
    input  logic [31:0]           reg2_data_i,
    input  logic                  ex_wreg_i,
    input  logic [REG_ADDR_W-1:0] ex_wd_i,
    input  logic [31:0]           ex_wdata_i,
    input  logic                  ex_is_load_i,
    input  logic                  mem_wreg_i,
    input  logic [REG_ADDR_W-1:0] mem_wd_i,
    input  logic [31:0]           mem_wdata_i,
    output logic                  reg1_re_o,
    output logic [REG_ADDR_W-1:0] reg1_addr_o,
    output logic                  reg2_re_o,
    output logic [REG_ADDR_W-1:0] reg2_addr_o,
    output alu_op_e               alu_op_o,
    output logic [31:0]           reg1_o,
    output logic [31:0]           reg2_o,
    output logic                  wreg_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic [31:0]           store_data_o,
    output logic                  branch_flag_o,
    output logic [31:0]           branch_target_o,
    output logic                  stall_req_o
);

    op_e                   op;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rs, rt, rd;
    logic [31:0]           imm, imm_sext, pc_plus4;
    logic                  imm_op;
    logic [31:0]           rs_val, rt_val;

    assign op       = op_e'(inst_i[31:26]);
    assign funct    = funct_e'(inst_i[5:0]);
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign pc_plus4 = pc_i + 32'd4;

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    function automatic logic [31:0] fwd(input logic [REG_ADDR_W-1:0] addr,
                                        input logic [31:0] rf_data);
        logic [31:0] val;
        if (addr != '0 && ex_wreg_i && ex_wd_i == addr) begin
            val = ex_wdata_i; // youngest producer first
        end else if (addr != '0 && mem_wreg_i && mem_wd_i == addr) begin
            val = mem_wdata_i;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        rs_val = fwd(rs, reg1_data_i);
        rt_val = fwd(rt, reg2_data_i);
    end

    always_comb begin
        alu_op_o      = ALU_NOP;
        reg1_re_o     = 1'b0;
        reg2_re_o     = 1'b0;
        wreg_o        = 1'b0;
        wd_o          = rt;
        mem_read_o    = 1'b0;
        mem_write_o   = 1'b0;
        imm           = imm_sext;
        imm_op        = 1'b1;
        branch_flag_o = 1'b0;
        case (op)
            OP_SPECIAL: begin
                reg1_re_o = 1'b1;
                reg2_re_o = 1'b1;
                wreg_o    = 1'b1;
                wd_o      = rd;
                imm_op    = 1'b0;
                case (funct)
                    F_ADDU: alu_op_o = ALU_ADD;
                    F_SUBU: alu_op_o = ALU_SUB;
                    F_AND:  alu_op_o = ALU_AND;
                    F_OR:   alu_op_o = ALU_OR;
                    F_XOR:  alu_op_o = ALU_XOR;
                    F_SLT:  alu_op_o = ALU_SLT;
                    F_SLL: begin
                        alu_op_o  = ALU_SLL;
                        reg1_re_o = 1'b0;
                        imm       = {27'b0, inst_i[10:6]}; // sa goes in as reg1
                    end
                    default: wreg_o = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op_o  = ALU_ADD;
                reg1_re_o = 1'b1;
                wreg_o    = 1'b1;
            end
            OP_ORI: begin
                alu_op_o  = ALU_OR;
                reg1_re_o = 1'b1;
                wreg_o    = 1'b1;
                imm       = {16'b0, inst_i[15:0]};
            end
            OP_LUI: begin
                alu_op_o = ALU_LUI;
                wreg_o   = 1'b1;
                imm      = {inst_i[15:0], 16'b0};
            end
            OP_LW: begin
                alu_op_o   = ALU_ADD;
                reg1_re_o  = 1'b1;
                wreg_o     = 1'b1;
                mem_read_o = 1'b1;
            end
            OP_SW: begin
                alu_op_o    = ALU_ADD;
                reg1_re_o   = 1'b1;
                reg2_re_o   = 1'b1; // rt is the store data
                mem_write_o = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                reg1_re_o     = 1'b1;
                reg2_re_o     = 1'b1;
                branch_flag_o = (rs_val == rt_val) ^ (op == OP_BNE);
            end
            OP_J: branch_flag_o = 1'b1;
            default: imm_op = 1'b0;
        endcase
    end

    assign reg1_o       = reg1_re_o ? rs_val : imm;
    assign reg2_o       = imm_op ? imm : rt_val;
    assign store_data_o = rt_val;

    assign branch_target_o = (op == OP_J) ? {pc_plus4[31:28], inst_i[25:0], 2'b00}
                                          : pc_plus4 + {imm_sext[29:0], 2'b00};

    // load in execute feeding this instruction
    assign stall_req_o = !rst && ex_is_load_i && ex_wd_i != '0 &&
                         ((reg1_re_o && ex_wd_i == rs) || (reg2_re_o && ex_wd_i == rt));

endmodule

//--- rtl/id_ex.sv
`timescale 1ns/100ps

module id_ex
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  alu_op_e               alu_op_i,
    input  logic [31:0]           reg1_i,
    input  logic [31:0]           reg2_i,
    input  logic                  wreg_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic [31:0]           store_data_i,
    input  logic [31:0]           pc_i,
    output alu_op_e               ex_alu_op_o,
    output logic [31:0]           ex_reg1_o,
    output logic [31:0]           ex_reg2_o,
    output logic                  ex_wreg_o,
    output logic [REG_ADDR_W-1:0] ex_wd_o,
    output logic                  ex_mem_read_o,
    output logic                  ex_mem_write_o,
    output logic [31:0]           ex_store_data_o,
    output logic [31:0]           ex_pc_o
);

    // bubble on stall: no write, no memory access
    always_ff @(posedge clk) begin
        if (rst || stall_i) begin
            ex_alu_op_o    <= ALU_NOP;
            ex_wreg_o      <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
        end else begin
            ex_alu_op_o    <= alu_op_i;
            ex_wreg_o      <= wreg_i;
            ex_mem_read_o  <= mem_read_i;
            ex_mem_write_o <= mem_write_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_reg1_o       <= reg1_i;
        ex_reg2_o       <= reg2_i;
        ex_wd_o         <= wd_i;
        ex_store_data_o <= store_data_i;
        ex_pc_o         <= pc_i;
    end

endmodule

//--- rtl/ifetch.sv
`timescale 1ns/100ps

module ifetch #(
    parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_i,
    input  logic        branch_flag_i,
    input  logic [31:0] branch_target_i,
    input  logic [31:0] inst_rdata_i,
    output logic        inst_ce_o,
    output logic [31:0] inst_addr_o,
    output logic [31:0] id_pc_o,
    output logic [31:0] id_inst_o
);

    logic [31:0] pc;

    assign inst_addr_o = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            inst_ce_o <= 1'b0;
        end else begin
            inst_ce_o <= 1'b1;
            if (inst_ce_o && !stall_i) begin // first fetch is at RESET_PC
                pc <= branch_flag_i ? branch_target_i : pc + 32'd4;
            end
        end
    end

    // IF/ID register held while decode waits on a load
    always_ff @(posedge clk) begin
        if (rst) begin
            id_pc_o <= '0;
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_pc_o <= pc;
            id_inst_o <= inst_ce_o ? inst_rdata_i : '0; // nop until fetch starts
        end
    end

endmodule

//--- rtl/mem.sv
`timescale 1ns/100ps

module mem
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           pc_i,
    input  logic                  wreg_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic [31:0]           wdata_i,
    input  logic                  mem_read_i,
    input  logic                  mem_write_i,
    input  logic [31:0]           mem_addr_i,
    input  logic [31:0]           store_data_i,
    input  logic [31:0]           ram_data_i,
    output logic                  ram_ce_o,
    output logic                  ram_we_o,
    output logic [3:0]            ram_sel_o,
    output logic [31:0]           ram_addr_o,
    output logic [31:0]           ram_data_o,
    output logic                  fwd_wreg_o,
    output logic [REG_ADDR_W-1:0] fwd_wd_o,
    output logic [31:0]           fwd_wdata_o,
    output logic [31:0]           wb_pc_o,
    output logic                  wb_wreg_o,
    output logic [REG_ADDR_W-1:0] wb_wd_o,
    output logic [31:0]           wb_wdata_o
);

    assign ram_ce_o   = mem_read_i || mem_write_i;
    assign ram_we_o   = mem_write_i;
    assign ram_sel_o  = {4{mem_write_i}}; // word stores only
    assign ram_addr_o = mem_addr_i;
    assign ram_data_o = store_data_i;

    // loaded word replaces the address computed in execute
    assign fwd_wreg_o  = wreg_i;
    assign fwd_wd_o    = wd_i;
    assign fwd_wdata_o = mem_read_i ? ram_data_i : wdata_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wreg_o <= 1'b0;
        end else begin
            wb_wreg_o <= wreg_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_wd_o    <= wd_i;
        wb_wdata_o <= fwd_wdata_o;
        wb_pc_o    <= pc_i;
    end

endmodule

//--- rtl/mips.sv
`timescale 1ns/100ps

module mips
    import mips_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        rst,
    output logic        inst_ce_o,
    output logic [31:0] inst_addr_o,
    input  logic [31:0] inst_rdata_i,
    output logic        ram_ce_o,
    output logic        ram_we_o,
    output logic [3:0]  ram_sel_o,
    output logic [31:0] ram_addr_o,
    output logic [31:0] ram_data_o,
    input  logic [31:0] ram_data_i,
    output logic [31:0] debug_wb_pc_o,
    output logic [3:0]  debug_wb_rf_wen_o,
    output logic [4:0]  debug_wb_rf_wnum_o,
    output logic [31:0] debug_wb_rf_wdata_o
);

    logic [31:0]           id_pc, id_inst, branch_target;
    logic                  branch_flag, stall_req;
    logic                  reg1_re, reg2_re;
    logic [REG_ADDR_W-1:0] reg1_addr, reg2_addr;
    logic [31:0]           reg1_data, reg2_data;
    alu_op_e               id_alu_op, idex_alu_op;
    logic [31:0]           id_reg1, id_reg2, id_store_data;
    logic                  id_wreg, id_mem_read, id_mem_write;
    logic [REG_ADDR_W-1:0] id_wd, idex_wd, ex_wd, exmem_wd, fwd_wd, wb_wd;
    logic [31:0]           idex_reg1, idex_reg2, idex_store_data, idex_pc;
    logic                  idex_wreg, idex_mem_read, idex_mem_write;
    logic                  ex_wreg, ex_is_load, ex_mem_read, ex_mem_write;
    logic [31:0]           ex_wdata, ex_mem_addr, ex_store_data;
    logic                  exmem_wreg, exmem_mem_read, exmem_mem_write;
    logic [31:0]           exmem_wdata, exmem_mem_addr, exmem_store_data, exmem_pc;
    logic                  fwd_wreg, wb_wreg;
    logic [31:0]           fwd_wdata, wb_wdata, wb_pc;

    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_wen_o   = {4{wb_wreg && wb_wd != '0}};
    assign debug_wb_rf_wnum_o  = wb_wd;
    assign debug_wb_rf_wdata_o = wb_wdata;

    ifetch #(.RESET_PC(RESET_PC)) if0(.clk(clk), .rst(rst), .stall_i(stall_req),
        .branch_flag_i(branch_flag), .branch_target_i(branch_target),
        .inst_rdata_i(inst_rdata_i), .inst_ce_o(inst_ce_o), .inst_addr_o(inst_addr_o),
        .id_pc_o(id_pc), .id_inst_o(id_inst));

    id id0(.rst(rst), .pc_i(id_pc), .inst_i(id_inst),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata), .ex_is_load_i(ex_is_load),
        .mem_wreg_i(fwd_wreg), .mem_wd_i(fwd_wd), .mem_wdata_i(fwd_wdata),
        .reg1_re_o(reg1_re), .reg1_addr_o(reg1_addr), .reg2_re_o(reg2_re), .reg2_addr_o(reg2_addr),
        .alu_op_o(id_alu_op), .reg1_o(id_reg1), .reg2_o(id_reg2),
        .wreg_o(id_wreg), .wd_o(id_wd), .mem_read_o(id_mem_read), .mem_write_o(id_mem_write),
        .store_data_o(id_store_data), .branch_flag_o(branch_flag),
        .branch_target_o(branch_target), .stall_req_o(stall_req));

    regfile regfile0(.clk(clk), .rst(rst), .we_i(wb_wreg), .waddr_i(wb_wd), .wdata_i(wb_wdata),
        .re1_i(reg1_re), .raddr1_i(reg1_addr), .rdata1_o(reg1_data),
        .re2_i(reg2_re), .raddr2_i(reg2_addr), .rdata2_o(reg2_data));

    id_ex id_ex0(.clk(clk), .rst(rst), .stall_i(stall_req),
        .alu_op_i(id_alu_op), .reg1_i(id_reg1), .reg2_i(id_reg2), .wreg_i(id_wreg), .wd_i(id_wd),
        .mem_read_i(id_mem_read), .mem_write_i(id_mem_write), .store_data_i(id_store_data),
        .pc_i(id_pc), .ex_alu_op_o(idex_alu_op), .ex_reg1_o(idex_reg1), .ex_reg2_o(idex_reg2),
        .ex_wreg_o(idex_wreg), .ex_wd_o(idex_wd), .ex_mem_read_o(idex_mem_read),
        .ex_mem_write_o(idex_mem_write), .ex_store_data_o(idex_store_data), .ex_pc_o(idex_pc));

    ex ex0(.alu_op_i(idex_alu_op), .reg1_i(idex_reg1), .reg2_i(idex_reg2),
        .wreg_i(idex_wreg), .wd_i(idex_wd), .mem_read_i(idex_mem_read),
        .mem_write_i(idex_mem_write), .store_data_i(idex_store_data),
        .wreg_o(ex_wreg), .wd_o(ex_wd), .wdata_o(ex_wdata), .is_load_o(ex_is_load),
        .mem_addr_o(ex_mem_addr), .mem_read_o(ex_mem_read), .mem_write_o(ex_mem_write),
        .store_data_o(ex_store_data));

    ex_mem ex_mem0(.clk(clk), .rst(rst), .wreg_i(ex_wreg), .wd_i(ex_wd), .wdata_i(ex_wdata),
        .mem_addr_i(ex_mem_addr), .mem_read_i(ex_mem_read), .mem_write_i(ex_mem_write),
        .store_data_i(ex_store_data), .pc_i(idex_pc),
        .mem_wreg_o(exmem_wreg), .mem_wd_o(exmem_wd), .mem_wdata_o(exmem_wdata),
        .mem_addr_o(exmem_mem_addr), .mem_read_o(exmem_mem_read), .mem_write_o(exmem_mem_write),
        .mem_store_data_o(exmem_store_data), .mem_pc_o(exmem_pc));

    mem mem0(.clk(clk), .rst(rst), .pc_i(exmem_pc), .wreg_i(exmem_wreg), .wd_i(exmem_wd),
        .wdata_i(exmem_wdata), .mem_read_i(exmem_mem_read), .mem_write_i(exmem_mem_write),
        .mem_addr_i(exmem_mem_addr), .store_data_i(exmem_store_data), .ram_data_i(ram_data_i),
        .ram_ce_o(ram_ce_o), .ram_we_o(ram_we_o), .ram_sel_o(ram_sel_o),
        .ram_addr_o(ram_addr_o), .ram_data_o(ram_data_o),
        .fwd_wreg_o(fwd_wreg), .fwd_wd_o(fwd_wd), .fwd_wdata_o(fwd_wdata),
        .wb_pc_o(wb_pc), .wb_wreg_o(wb_wreg), .wb_wd_o(wb_wd), .wb_wdata_o(wb_wdata));

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    localparam int REG_ADDR_W = 5;

    // primary opcode field, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } op_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [31:0]           wdata_i,
    input  logic                  re1_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    output logic [31:0]           rdata1_o,
    input  logic                  re2_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [31:0]           rdata2_o
);

    logic [31:0] regs [32];
    logic        wr_en;

    assign wr_en = we_i && !rst && waddr_i != '0; // r0 stays zero

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic logic [31:0] read_port(input logic re,
                                              input logic [REG_ADDR_W-1:0] addr);
        logic [31:0] val;
        if (!re || addr == '0) begin
            val = '0;
        end else if (wr_en && addr == waddr_i) begin
            val = wdata_i; // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rdata1_o = read_port(re1_i, raddr1_i);
        rdata2_o = read_port(re2_i, raddr2_i);
    end

endmodule

//--- tb.f
rtl/mips_pkg.sv
rtl/ifetch.sv
rtl/id.sv
rtl/regfile.sv
rtl/id_ex.sv
rtl/ex.sv
rtl/ex_mem.sv
rtl/mem.sv
rtl/mips.sv
bench/clk_gen.sv
bench/tb_mips.sv
